/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = roce_stack_tb
FILELIST = all.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "sim failed" $(LOG) || ! grep -q "sim passed" $(LOG); then \
		echo "Result: FAIL"; exit 1; \
	else \
		echo "Result: PASS"; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

/* all.f */
common/roce_pkg.sv
source/payload_gen.sv
source/stream_fifo.sv
roce_tx/roce_header_producer.sv
roce_tx/roce_udp_tx.sv
source/roce_stack.sv
bench/roce_stack_sva.sv
bench/roce_stack_tb.sv

/* bench/roce_stack_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module roce_stack_sva import roce_pkg::*; (
  input logic             clk,
  input logic             rst,
  input logic             start_transfer,
  input logic [LEN_W-1:0] transfer_length,
  input logic             hdr_valid,
  input logic             hdr_ready,
  input logic [7:0]       hdr_op_code,
  input logic [23:0]      hdr_dest_qp,
  input logic [23:0]      hdr_psn,
  input logic [31:0]      hdr_r_key,
  input logic [63:0]      hdr_v_addr,
  input logic [LEN_W-1:0] hdr_length,
  input logic [31:0]      hdr_dest_ip,
  input logic [15:0]      hdr_udp_length,
  input logic             pay_valid,
  input logic             pay_ready,
  input logic             pay_last
);

  logic hdr_taken;  // Set by the header handshake, cleared by the last payload beat.

  always_ff @(posedge clk) begin
    if (rst) begin
      hdr_taken <= 1'b0;
    end else if (hdr_valid && hdr_ready) begin
      hdr_taken <= 1'b1;
    end else if (pay_valid && pay_ready && pay_last) begin
      hdr_taken <= 1'b0;
    end
  end

  // A header that is not taken stays up with the same fields.
  hdr_hold: assert property (@(posedge clk) disable iff (rst)
    hdr_valid && !hdr_ready |=> hdr_valid && $stable({hdr_op_code, hdr_dest_qp, hdr_psn,
      hdr_r_key, hdr_v_addr, hdr_length, hdr_dest_ip, hdr_udp_length}))
    else $error("Header dropped or changed before hdr_ready.");

  pay_hold: assert property (@(posedge clk) disable iff (rst)
    pay_valid && !pay_ready |=> pay_valid)
    else $error("Payload beat dropped before pay_ready.");

  pay_after_hdr: assert property (@(posedge clk) disable iff (rst)
    pay_valid |-> hdr_taken)
    else $error("Payload offered before the header was accepted.");

  // One transfer is one packet.
  len_limit: assert property (@(posedge clk) disable iff (rst)
    $rose(start_transfer) |-> transfer_length <= LEN_W'(PMTU_BYTES))
    else $error("Start given with a length above the PMTU.");

endmodule

bind roce_stack roce_stack_sva roce_stack_sva_i (
  .clk             (clk),
  .rst             (rst),
  .start_transfer  (start_transfer),
  .transfer_length (transfer_length),
  .hdr_valid       (hdr_valid),
  .hdr_ready       (hdr_ready),
  .hdr_op_code     (hdr_op_code),
  .hdr_dest_qp     (hdr_dest_qp),
  .hdr_psn         (hdr_psn),
  .hdr_r_key       (hdr_r_key),
  .hdr_v_addr      (hdr_v_addr),
  .hdr_length      (hdr_length),
  .hdr_dest_ip     (hdr_dest_ip),
  .hdr_udp_length  (hdr_udp_length),
  .pay_valid       (pay_valid),
  .pay_ready       (pay_ready),
  .pay_last        (pay_last)
);

`default_nettype wire

/* bench/roce_stack_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module roce_stack_tb import roce_pkg::*; ();

  localparam int         CLK_PERIOD   = 40;
  localparam int         FIFO_DEPTH   = 256;
  localparam int         UDP_OVERHEAD = 36;     // UDP, BTH and RETH bytes.
  localparam logic [7:0] WRITE_ONLY   = 8'h0A;

  // Beats over all tests, with slack for reset, headers and random stalls.
  localparam int TEST_BEATS      = 8 + 4 + 20 + 38 + 64;
  localparam int MARGIN_BEATS    = 250;
  localparam int WATCHDOG_CYCLES = (TEST_BEATS + MARGIN_BEATS) * 4;

  logic              clk;
  logic              rst;
  logic [LEN_W-1:0]  transfer_length;
  logic [23:0]       rem_qpn;
  logic [23:0]       rem_psn;
  logic [31:0]       r_key;
  logic [63:0]       rem_addr;
  logic [31:0]       rem_ip_addr;
  logic              start_transfer;
  logic              hdr_valid;
  logic              hdr_ready;
  logic [7:0]        hdr_op_code;
  logic [23:0]       hdr_dest_qp;
  logic [23:0]       hdr_psn;
  logic [31:0]       hdr_r_key;
  logic [63:0]       hdr_v_addr;
  logic [LEN_W-1:0]  hdr_length;
  logic [31:0]       hdr_dest_ip;
  logic [15:0]       hdr_udp_length;
  logic [DATA_W-1:0] pay_data;
  logic [KEEP_W-1:0] pay_keep;
  logic              pay_valid;
  logic              pay_last;
  logic              pay_ready;
  logic              busy;

  integer seed;
  int     errors;
  int     checks;

  roce_stack #(.FIFO_DEPTH (FIFO_DEPTH)) roce_stack_i (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic int beat_count(input int len);
    return (len + KEEP_W - 1) / KEEP_W;
  endfunction

  // Byte offset in the low half, its inverse in the high half.
  function automatic logic [DATA_W-1:0] beat_data(input int beat);
    logic [31:0] offset;
    offset = 32'(beat * KEEP_W);
    return {~offset, offset};
  endfunction

  function automatic logic [KEEP_W-1:0] beat_keep(input int len, input int beat);
    logic [KEEP_W-1:0] mask;
    int                tail;
    mask = '1;
    tail = len % KEEP_W;
    if (beat == beat_count(len) - 1 && tail != 0) begin
      mask = mask >> (KEEP_W - tail);
    end
    return mask;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks and stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic check_field(input string test, input string field,
                             input logic [63:0] expected, input logic [63:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("FAILED %s %s: expected %0h, actual %0h", test, field, expected, actual);
    end
  endtask

  task automatic check_cond(input string test, input string what, input bit ok);
    checks++;
    assert (ok) else begin
      errors++;
      $display("ERROR %s: %s", test, what);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #2;
    rst            = 1'b1;
    start_transfer = 1'b0;
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;
  endtask

  task automatic randomize_config();
    rem_qpn     = 24'($random(seed));
    rem_psn     = 24'($random(seed));
    r_key       = 32'($random(seed));
    rem_addr    = {32'($random(seed)), 32'($random(seed))};
    rem_ip_addr = 32'($random(seed));
  endtask

  task automatic check_header(input string test, input int len, input logic [23:0] psn);
    check_field(test, "op_code", 64'(WRITE_ONLY), 64'(hdr_op_code));
    check_field(test, "dest_qp", 64'(rem_qpn), 64'(hdr_dest_qp));
    check_field(test, "psn", 64'(psn), 64'(hdr_psn));
    check_field(test, "r_key", 64'(r_key), 64'(hdr_r_key));
    check_field(test, "v_addr", rem_addr, hdr_v_addr);
    check_field(test, "length", 64'(len), 64'(hdr_length));
    check_field(test, "dest_ip", 64'(rem_ip_addr), 64'(hdr_dest_ip));
    check_field(test, "udp_length", 64'(len + UDP_OVERHEAD), 64'(hdr_udp_length));
    check_cond(test, "busy is low while the header is offered", busy);
  endtask

  // Each frame is len + 11 * index bytes long. Outputs are sampled on the falling edge.
  task automatic run_transfer(input string test, input int len, input int frames,
                              input bit stall, input int restart_at);
    int frame_len;
    int beat;
    int cycle;
    bit hdr_seen;
    bit done;
    for (int f = 0; f < frames; f++) begin
      frame_len = len + f * 11;
      hdr_seen  = 1'b0;
      done      = 1'b0;
      beat      = 0;
      cycle     = 0;
      @(posedge clk);
      #2;
      transfer_length = LEN_W'(frame_len);
      start_transfer  = 1'b1;
      while (!done) begin
        @(negedge clk);
        if (pay_valid) begin
          check_cond(test, "payload offered before the header was accepted", hdr_seen);
        end
        if (hdr_valid && hdr_ready) begin
          check_cond(test, "more than one header for one transfer", !hdr_seen);
          check_header(test, frame_len, rem_psn + 24'(f));
          hdr_seen = 1'b1;
        end
        if (pay_valid && pay_ready) begin
          check_field(test, "data", beat_data(beat), pay_data);
          check_field(test, "keep", 64'(beat_keep(frame_len, beat)), 64'(pay_keep));
          check_field(test, "last", 64'(beat == beat_count(frame_len) - 1), 64'(pay_last));
          beat++;
          done = pay_last || (beat == beat_count(frame_len));
        end
        @(posedge clk);
        #2;
        cycle++;
        start_transfer = (restart_at != 0) && (cycle == restart_at);
        if (start_transfer) begin
          transfer_length = LEN_W'(64);  // This length must never show up.
        end
        hdr_ready = stall ? 1'($random(seed)) : 1'b1;
        pay_ready = stall ? 1'($random(seed)) : 1'b1;
      end
      hdr_ready = 1'b1;
      pay_ready = 1'b1;
      @(negedge clk);
      check_cond(test, "busy still high after the last beat", !busy);
      check_field(test, "beats", 64'(beat_count(frame_len)), 64'(beat));
    end
    repeat (12) begin
      @(negedge clk);
      check_cond(test, "activity after the transfer ended", !hdr_valid && !pay_valid && !busy);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic test_write_64();
    apply_reset();
    randomize_config();
    run_transfer("write_64", 64, 1, 1'b0, 0);
  endtask

  task automatic test_write_29();
    apply_reset();
    randomize_config();
    run_transfer("write_29", 29, 1, 1'b0, 0);  // Partial last beat.
  endtask

  task automatic test_back_to_back();
    apply_reset();
    randomize_config();
    run_transfer("back_to_back", 40, 3, 1'b0, 0);
  endtask

  task automatic test_random_ready();
    apply_reset();
    randomize_config();
    run_transfer("random_ready", 300, 1, 1'b1, 0);
  endtask

  task automatic test_restart_ignored();
    apply_reset();
    randomize_config();
    run_transfer("restart_ignored", 512, 1, 1'b0, 10);
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d clock cycles.", WATCHDOG_CYCLES);
    $display("sim failed");
    $finish;
  end

  initial begin
    seed            = 77873;
    errors          = 0;
    checks          = 0;
    clk             = 1'b0;
    rst             = 1'b1;
    start_transfer  = 1'b0;
    transfer_length = '0;
    rem_qpn         = '0;
    rem_psn         = '0;
    r_key           = '0;
    rem_addr        = '0;
    rem_ip_addr     = '0;
    hdr_ready       = 1'b1;
    pay_ready       = 1'b1;
    test_write_64();
    test_write_29();
    test_back_to_back();
    test_random_ready();
    test_restart_ignored();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* common/roce_pkg.sv */
`default_nettype none

package roce_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Payload stream
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int DATA_W = 64;
  localparam int KEEP_W = DATA_W / 8;  // One keep bit per byte.
  localparam int LEN_W  = 16;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // RoCEv2 headers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Header sizes in bytes.
  localparam int BTH_BYTES     = 12;
  localparam int RETH_BYTES    = 16;
  localparam int UDP_HDR_BYTES = 8;

  localparam logic [7:0] OP_RDMA_WRITE_ONLY = 8'h0A;

  // Every transfer goes out as a single packet, so this is also the largest
  // transfer length.
  localparam int PMTU_BYTES = 2048;

endpackage

`default_nettype wire

/* roce_tx/roce_header_producer.sv */
`timescale 1ns/1ps
`default_nettype none

module roce_header_producer import roce_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic [LEN_W-1:0] transfer_length,
  input  logic [23:0]      rem_qpn,
  input  logic [23:0]      rem_psn,
  input  logic [31:0]      r_key,
  input  logic [63:0]      rem_addr,
  input  logic [31:0]      rem_ip_addr,
  input  logic             start_transfer,
  input  logic             fifo_valid,
  input  logic             fifo_ready,
  input  logic             fifo_last,
  output logic             req_valid,
  output logic [7:0]       req_op_code,
  output logic [23:0]      req_dest_qp,
  output logic [23:0]      req_psn,
  output logic [31:0]      req_r_key,
  output logic [63:0]      req_v_addr,
  output logic [LEN_W-1:0] req_length,
  output logic [31:0]      req_dest_ip,
  output logic [15:0]      req_udp_length,
  input  logic             req_ready
);

  logic             start_q;
  logic             armed;     // Start seen, first beat not yet at the FIFO output.
  logic             in_frame;
  logic             psn_init;
  logic [23:0]      psn;
  logic [LEN_W-1:0] len_q;
  logic             accept_start;
  logic             frame_first;

  assign accept_start = start_transfer && !start_q && !armed && !in_frame &&
                        (transfer_length != '0);
  assign frame_first  = fifo_valid && !in_frame;

  always_ff @(posedge clk) begin
    if (rst) begin
      start_q   <= 1'b0;
      armed     <= 1'b0;
      in_frame  <= 1'b0;
      psn_init  <= 1'b0;
      psn       <= '0;
      req_valid <= 1'b0;
    end else begin
      start_q <= start_transfer;
      if (accept_start) begin
        armed <= 1'b1;
        if (!psn_init) begin
          psn      <= rem_psn;  // Sequence starts from the configured PSN.
          psn_init <= 1'b1;
        end
      end
      if (req_valid && req_ready) begin
        req_valid <= 1'b0;
        psn       <= psn + 24'd1;
      end
      if (frame_first) begin
        in_frame  <= 1'b1;
        armed     <= 1'b0;
        req_valid <= 1'b1;
      end else if (fifo_valid && fifo_ready && fifo_last) begin
        in_frame <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept_start) begin
      len_q <= transfer_length;
    end
    if (frame_first) begin
      req_dest_qp <= rem_qpn;
      req_r_key   <= r_key;
      req_v_addr  <= rem_addr;
      req_dest_ip <= rem_ip_addr;
    end
  end

  assign req_op_code    = OP_RDMA_WRITE_ONLY;
  assign req_psn        = psn;  // Only steps on acceptance, so stable while valid.
  assign req_length     = len_q;
  assign req_udp_length = 16'(UDP_HDR_BYTES + BTH_BYTES + RETH_BYTES) + 16'(len_q);

endmodule

`default_nettype wire

/* roce_tx/roce_udp_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module roce_udp_tx import roce_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              req_valid,
  output logic              req_ready,
  input  logic [7:0]        req_op_code,
  input  logic [23:0]       req_dest_qp,
  input  logic [23:0]       req_psn,
  input  logic [31:0]       req_r_key,
  input  logic [63:0]       req_v_addr,
  input  logic [LEN_W-1:0]  req_length,
  input  logic [31:0]       req_dest_ip,
  input  logic [15:0]       req_udp_length,
  input  logic [DATA_W-1:0] fifo_data,
  input  logic [KEEP_W-1:0] fifo_keep,
  input  logic              fifo_valid,
  input  logic              fifo_last,
  output logic              fifo_ready,
  output logic              hdr_valid,
  input  logic              hdr_ready,
  output logic [7:0]        hdr_op_code,
  output logic [23:0]       hdr_dest_qp,
  output logic [23:0]       hdr_psn,
  output logic [31:0]       hdr_r_key,
  output logic [63:0]       hdr_v_addr,
  output logic [LEN_W-1:0]  hdr_length,
  output logic [31:0]       hdr_dest_ip,
  output logic [15:0]       hdr_udp_length,
  output logic [DATA_W-1:0] pay_data,
  output logic [KEEP_W-1:0] pay_keep,
  output logic              pay_valid,
  output logic              pay_last,
  input  logic              pay_ready,
  output logic              busy
);

  localparam logic [1:0] ST_IDLE    = 2'd0;
  localparam logic [1:0] ST_HEADER  = 2'd1;
  localparam logic [1:0] ST_PAYLOAD = 2'd2;

  logic [1:0] state;

  assign req_ready = (state == ST_IDLE);
  assign hdr_valid = (state == ST_HEADER);
  assign busy      = (state != ST_IDLE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req_valid) begin
            state <= ST_HEADER;
          end
        end
        ST_HEADER: begin
          if (hdr_ready) begin
            state <= ST_PAYLOAD;
          end
        end
        ST_PAYLOAD: begin
          if (pay_valid && pay_ready && pay_last) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // Header fields are held here for the whole hdr handshake.
  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      hdr_op_code    <= req_op_code;
      hdr_dest_qp    <= req_dest_qp;
      hdr_psn        <= req_psn;
      hdr_r_key      <= req_r_key;
      hdr_v_addr     <= req_v_addr;
      hdr_length     <= req_length;
      hdr_dest_ip    <= req_dest_ip;
      hdr_udp_length <= req_udp_length;
    end
  end

  // Payload is released only after the header has gone out.
  assign pay_data   = fifo_data;
  assign pay_keep   = fifo_keep;
  assign pay_last   = fifo_last;
  assign pay_valid  = (state == ST_PAYLOAD) && fifo_valid;
  assign fifo_ready = (state == ST_PAYLOAD) && pay_ready;

endmodule

`default_nettype wire

/* source/payload_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module payload_gen import roce_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              start_transfer,
  input  logic [LEN_W-1:0]  transfer_length,
  output logic [DATA_W-1:0] data,
  output logic [KEEP_W-1:0] keep,
  output logic              valid,
  input  logic              ready,
  output logic              last
);

  localparam int HALF_W = DATA_W / 2;
  localparam int REM_W  = $clog2(KEEP_W);

  logic              start_q;
  logic              load_q;
  logic              active;
  logic              accept_start;
  logic [LEN_W-1:0]  len_q;
  logic [LEN_W-1:0]  offset;
  logic [HALF_W-1:0] offset_word;
  logic [REM_W-1:0]  tail_bytes;
  logic [KEEP_W-1:0] tail_keep;

  // A start edge is dropped while a frame is loading or being emitted.
  assign accept_start = start_transfer && !start_q && !load_q && !active &&
                        (transfer_length != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      start_q <= 1'b0;
      load_q  <= 1'b0;
      active  <= 1'b0;
    end else begin
      start_q <= start_transfer;
      load_q  <= accept_start;
      if (load_q) begin
        active <= 1'b1;
      end else if (valid && ready && last) begin
        active <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept_start) begin
      len_q <= transfer_length;
    end
    if (load_q) begin
      offset <= '0;
    end else if (valid && ready) begin
      offset <= offset + LEN_W'(KEEP_W);  // Byte offset of the next beat.
    end
  end

  assign offset_word = HALF_W'(offset);
  assign data        = {~offset_word, offset_word};
  assign valid       = active;
  assign last        = ({1'b0, offset} + (LEN_W + 1)'(KEEP_W)) >= {1'b0, len_q};

  // Partial last beat keeps the low bytes only.
  assign tail_bytes = len_q[REM_W-1:0];
  assign tail_keep  = (tail_bytes == '0) ? '1 : KEEP_W'((1 << tail_bytes) - 1);
  assign keep       = last ? tail_keep : '1;

endmodule

`default_nettype wire

/* source/roce_stack.sv */
`timescale 1ns/1ps
`default_nettype none

module roce_stack import roce_pkg::*; #(
  parameter int FIFO_DEPTH = 256
) (
  input  logic              clk,
  input  logic              rst,
  input  logic [LEN_W-1:0]  transfer_length,
  input  logic [23:0]       rem_qpn,
  input  logic [23:0]       rem_psn,
  input  logic [31:0]       r_key,
  input  logic [63:0]       rem_addr,
  input  logic [31:0]       rem_ip_addr,
  input  logic              start_transfer,
  output logic              hdr_valid,
  input  logic              hdr_ready,
  output logic [7:0]        hdr_op_code,
  output logic [23:0]       hdr_dest_qp,
  output logic [23:0]       hdr_psn,
  output logic [31:0]       hdr_r_key,
  output logic [63:0]       hdr_v_addr,
  output logic [LEN_W-1:0]  hdr_length,
  output logic [31:0]       hdr_dest_ip,
  output logic [15:0]       hdr_udp_length,
  output logic [DATA_W-1:0] pay_data,
  output logic [KEEP_W-1:0] pay_keep,
  output logic              pay_valid,
  output logic              pay_last,
  input  logic              pay_ready,
  output logic              busy
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Internal streams
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic [DATA_W-1:0] gen_data;
  logic [KEEP_W-1:0] gen_keep;
  logic              gen_valid;
  logic              gen_last;
  logic              gen_ready;

  logic [DATA_W-1:0] fifo_data;
  logic [KEEP_W-1:0] fifo_keep;
  logic              fifo_valid;
  logic              fifo_last;
  logic              fifo_ready;

  logic              req_valid;
  logic              req_ready;
  logic [7:0]        req_op_code;
  logic [23:0]       req_dest_qp;
  logic [23:0]       req_psn;
  logic [31:0]       req_r_key;
  logic [63:0]       req_v_addr;
  logic [LEN_W-1:0]  req_length;
  logic [31:0]       req_dest_ip;
  logic [15:0]       req_udp_length;

  payload_gen payload_gen_i (
    .clk             (clk),
    .rst             (rst),
    .start_transfer  (start_transfer),
    .transfer_length (transfer_length),
    .data            (gen_data),
    .keep            (gen_keep),
    .valid           (gen_valid),
    .ready           (gen_ready),
    .last            (gen_last)
  );

  stream_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) stream_fifo_i (
    .clk       (clk),
    .rst       (rst),
    .in_data   (gen_data),
    .in_keep   (gen_keep),
    .in_valid  (gen_valid),
    .in_last   (gen_last),
    .in_ready  (gen_ready),
    .out_data  (fifo_data),
    .out_keep  (fifo_keep),
    .out_valid (fifo_valid),
    .out_last  (fifo_last),
    .out_ready (fifo_ready)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Transmit path
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  roce_header_producer roce_header_producer_i (
    .clk             (clk),
    .rst             (rst),
    .transfer_length (transfer_length),
    .rem_qpn         (rem_qpn),
    .rem_psn         (rem_psn),
    .r_key           (r_key),
    .rem_addr        (rem_addr),
    .rem_ip_addr     (rem_ip_addr),
    .start_transfer  (start_transfer),
    .fifo_valid      (fifo_valid),
    .fifo_ready      (fifo_ready),
    .fifo_last       (fifo_last),
    .req_valid       (req_valid),
    .req_op_code     (req_op_code),
    .req_dest_qp     (req_dest_qp),
    .req_psn         (req_psn),
    .req_r_key       (req_r_key),
    .req_v_addr      (req_v_addr),
    .req_length      (req_length),
    .req_dest_ip     (req_dest_ip),
    .req_udp_length  (req_udp_length),
    .req_ready       (req_ready)
  );

  roce_udp_tx roce_udp_tx_i (
    .clk            (clk),
    .rst            (rst),
    .req_valid      (req_valid),
    .req_ready      (req_ready),
    .req_op_code    (req_op_code),
    .req_dest_qp    (req_dest_qp),
    .req_psn        (req_psn),
    .req_r_key      (req_r_key),
    .req_v_addr     (req_v_addr),
    .req_length     (req_length),
    .req_dest_ip    (req_dest_ip),
    .req_udp_length (req_udp_length),
    .fifo_data      (fifo_data),
    .fifo_keep      (fifo_keep),
    .fifo_valid     (fifo_valid),
    .fifo_last      (fifo_last),
    .fifo_ready     (fifo_ready),
    .hdr_valid      (hdr_valid),
    .hdr_ready      (hdr_ready),
    .hdr_op_code    (hdr_op_code),
    .hdr_dest_qp    (hdr_dest_qp),
    .hdr_psn        (hdr_psn),
    .hdr_r_key      (hdr_r_key),
    .hdr_v_addr     (hdr_v_addr),
    .hdr_length     (hdr_length),
    .hdr_dest_ip    (hdr_dest_ip),
    .hdr_udp_length (hdr_udp_length),
    .pay_data       (pay_data),
    .pay_keep       (pay_keep),
    .pay_valid      (pay_valid),
    .pay_last       (pay_last),
    .pay_ready      (pay_ready),
    .busy           (busy)
  );

endmodule

`default_nettype wire

/* source/stream_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_fifo import roce_pkg::*; #(
  parameter int FIFO_DEPTH = 256  // Must be a power of two.
) (
  input  logic              clk,
  input  logic              rst,
  input  logic [DATA_W-1:0] in_data,
  input  logic [KEEP_W-1:0] in_keep,
  input  logic              in_valid,
  input  logic              in_last,
  output logic              in_ready,
  output logic [DATA_W-1:0] out_data,
  output logic [KEEP_W-1:0] out_keep,
  output logic              out_valid,
  output logic              out_last,
  input  logic              out_ready
);

  localparam int AW     = $clog2(FIFO_DEPTH);
  localparam int WORD_W = DATA_W + KEEP_W + 1;

  logic [WORD_W-1:0] mem [FIFO_DEPTH];
  logic [AW:0]       wr_ptr;
  logic [AW:0]       rd_ptr;
  logic              full;
  logic              empty;
  logic [WORD_W-1:0] rd_word;

  // The extra pointer bit tells a full buffer from an empty one.
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  assign in_ready  = !full;
  assign out_valid = !empty;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (in_valid && in_ready) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (out_valid && out_ready) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      mem[wr_ptr[AW-1:0]] <= {in_last, in_keep, in_data};
    end
  end

  assign rd_word                        = mem[rd_ptr[AW-1:0]];
  assign {out_last, out_keep, out_data} = rd_word;

endmodule

`default_nettype wire
